//--- verilog/wired_pkg.sv
package wired_pkg;

  // ====================
  // operation groups
  // ====================
  typedef enum logic [2:0] {
    ALU_GTYPE_BW    = 3'd0,
    ALU_GTYPE_LI    = 3'd1,
    ALU_GTYPE_INT   = 3'd2,
    ALU_GTYPE_SFT   = 3'd3,
    ALU_GTYPE_COUNT = 3'd4,
    ALU_GTYPE_MISC  = 3'd5
  } alu_gtype_e;

  // ====================
  // subtypes per group
  // ====================
  // bitwise
  localparam logic [2:0] ALU_STYPE_NOR       = 3'd0;
  localparam logic [2:0] ALU_STYPE_AND       = 3'd1;
  localparam logic [2:0] ALU_STYPE_OR        = 3'd2;
  localparam logic [2:0] ALU_STYPE_XOR       = 3'd3;
  localparam logic [2:0] ALU_STYPE_ANDN      = 3'd4;
  localparam logic [2:0] ALU_STYPE_ORN       = 3'd5;

  // load immediate / pc relative
  localparam logic [2:0] ALU_STYPE_LUI       = 3'd0;
  localparam logic [2:0] ALU_STYPE_PCPLUS4   = 3'd1;
  localparam logic [2:0] ALU_STYPE_PCADDU12I = 3'd2;
  localparam logic [2:0] ALU_STYPE_PCADDI    = 3'd3;
  localparam logic [2:0] ALU_STYPE_PCALAU12I = 3'd4;

  // integer, bit 0 picks unsigned compare
  localparam logic [2:0] ALU_STYPE_ADD       = 3'd0;
  localparam logic [2:0] ALU_STYPE_SUB       = 3'd1;
  localparam logic [2:0] ALU_STYPE_SLT       = 3'd2;
  localparam logic [2:0] ALU_STYPE_SLTU      = 3'd3;

  // shifts
  localparam logic [2:0] ALU_STYPE_SRA       = 3'd0;
  localparam logic [2:0] ALU_STYPE_SRL       = 3'd1;
  localparam logic [2:0] ALU_STYPE_SLL       = 3'd2;
  localparam logic [2:0] ALU_STYPE_ROTR      = 3'd3;

  // counts: bit 0 counts zeros, bit 1 counts from the bottom
  localparam logic [2:0] ALU_STYPE_CLO       = 3'd0;
  localparam logic [2:0] ALU_STYPE_CLZ       = 3'd1;
  localparam logic [2:0] ALU_STYPE_CTO       = 3'd2;
  localparam logic [2:0] ALU_STYPE_CTZ       = 3'd3;

  // misc
  localparam logic [2:0] ALU_STYPE_EXTB      = 3'd0;
  localparam logic [2:0] ALU_STYPE_EXTH      = 3'd1;
  localparam logic [2:0] ALU_STYPE_MASKNEZ   = 3'd2;
  localparam logic [2:0] ALU_STYPE_MASKEQZ   = 3'd3;

  typedef logic [4:0] reg_idx_t;

  // incoming micro-op, imm lands in r0[19:0]
  typedef struct packed {
    logic        valid;
    alu_gtype_e  gtype;
    logic [2:0]  op;
    reg_idx_t    rs0;
    reg_idx_t    rs1;
    logic        use_imm;
    logic [19:0] imm;
    reg_idx_t    rd;
    logic [31:0] pc;
  } uop_t;

  typedef struct packed {
    logic        valid;
    alu_gtype_e  gtype;
    logic [2:0]  op;
    logic [31:0] r0;
    logic [31:0] r1;
    logic [31:0] pc;
    reg_idx_t    rd;
  } exec_t;

  typedef struct packed {
    logic        valid;
    reg_idx_t    rd;
    logic [31:0] data;
  } retire_t;

endpackage

//--- verilog/wired_lzc.sv
module wired_lzc #(
  parameter int WIDTH = 32,
  parameter int MODE  = 1
) (
  input  logic [WIDTH-1:0]         in_i,
  output logic [$clog2(WIDTH)-1:0] cnt_o,
  output logic                     empty_o
);

  localparam int CNT_W = $clog2(WIDTH);

  // scan[0] is the end we count from
  logic [WIDTH-1:0] scan;

  always_comb
  begin
    for (int i = 0; i < WIDTH; i++)
    begin
      if (MODE == 1)
        scan[i] = in_i[WIDTH-1-i];
      else
        scan[i] = in_i[i];
    end
  end

  // priority scan, lowest set position wins
  always_comb
  begin
    cnt_o   = '0;
    empty_o = 1'b1;
    for (int i = WIDTH - 1; i >= 0; i--)
    begin
      if (scan[i])
      begin
        cnt_o   = CNT_W'(i);
        empty_o = 1'b0;
      end
    end
  end

endmodule

//--- verilog/wired_alu.sv
module wired_alu (
  input  logic [31:0]           r0_i,
  input  logic [31:0]           r1_i,
  input  logic [31:0]           pc_i,
  input  wired_pkg::alu_gtype_e grand_op_i,
  input  logic [2:0]            op_i,
  output logic [31:0]           res_o
);

  import wired_pkg::*;

  logic [31:0] bw_res;
  logic [31:0] li_res;
  logic [31:0] int_res;
  logic [31:0] sft_res;
  logic [31:0] cnt_res;
  logic [31:0] misc_res;

  // group select
  always_comb
  begin
    case (grand_op_i)
      ALU_GTYPE_BW:    res_o = bw_res;
      ALU_GTYPE_LI:    res_o = li_res;
      ALU_GTYPE_INT:   res_o = int_res;
      ALU_GTYPE_SFT:   res_o = sft_res;
      ALU_GTYPE_COUNT: res_o = cnt_res;
      ALU_GTYPE_MISC:  res_o = misc_res;
      default:         res_o = '0;
    endcase
  end

  // ====================
  // bitwise
  // ====================
  always_comb
  begin
    case (op_i)
      ALU_STYPE_NOR:  bw_res = ~(r1_i | r0_i);
      ALU_STYPE_AND:  bw_res = r1_i & r0_i;
      ALU_STYPE_OR:   bw_res = r1_i | r0_i;
      ALU_STYPE_XOR:  bw_res = r1_i ^ r0_i;
      ALU_STYPE_ANDN: bw_res = r1_i & ~r0_i;
      ALU_STYPE_ORN:  bw_res = r1_i | ~r0_i;
      default:        bw_res = '0;
    endcase
  end

  // ====================
  // load immediate / pc
  // ====================
  logic [31:0] imm_hi;
  logic [31:0] imm_word;

  assign imm_hi   = {r0_i[19:0], 12'd0};
  assign imm_word = {{10{r0_i[19]}}, r0_i[19:0], 2'd0};

  always_comb
  begin
    case (op_i)
      ALU_STYPE_LUI:       li_res = imm_hi;
      ALU_STYPE_PCPLUS4:   li_res = pc_i + 32'd4;
      ALU_STYPE_PCADDU12I: li_res = pc_i + imm_hi;
      ALU_STYPE_PCADDI:    li_res = pc_i + imm_word;
      ALU_STYPE_PCALAU12I: li_res = (pc_i + imm_hi) & 32'hffff_f000;
      default:             li_res = '0;
    endcase
  end

  // ====================
  // integer
  // ====================
  // one subtractor for sub, slt and sltu
  logic        sgn_ext;
  logic [32:0] sub_a;
  logic [32:0] sub_b;
  logic [32:0] sub_res;

  assign sgn_ext = ~op_i[0];
  assign sub_a   = {~r1_i[31] & sgn_ext, r1_i};
  assign sub_b   = {~r0_i[31] & sgn_ext, r0_i};
  assign sub_res = sub_a - sub_b;

  always_comb
  begin
    case (op_i)
      ALU_STYPE_ADD:  int_res = r1_i + r0_i;
      ALU_STYPE_SUB:  int_res = sub_res[31:0];
      ALU_STYPE_SLT:  int_res = {31'd0, sub_res[32]};
      ALU_STYPE_SLTU: int_res = {31'd0, sub_res[32]};
      default:        int_res = '0;
    endcase
  end

  // ====================
  // shifts
  // ====================
  logic [4:0] shamt;
  logic [5:0] rot_back;

  assign shamt    = r0_i[4:0];
  assign rot_back = 6'd32 - {1'b0, shamt};

  always_comb
  begin
    case (op_i)
      ALU_STYPE_SRA:  sft_res = $signed(r1_i) >>> shamt;
      ALU_STYPE_SRL:  sft_res = r1_i >> shamt;
      ALU_STYPE_SLL:  sft_res = r1_i << shamt;
      // rot_back is 32 for a zero amount, the left part then drops out
      ALU_STYPE_ROTR: sft_res = (r1_i >> shamt) | (r1_i << rot_back);
      default:        sft_res = '0;
    endcase
  end

  // ====================
  // counts
  // ====================
  logic [31:0] cnt_src;
  logic [4:0]  lead_cnt;
  logic [4:0]  trail_cnt;
  logic        lead_empty;
  logic        trail_empty;
  logic [4:0]  sel_cnt;
  logic        sel_empty;

  // ones are counted as zeros of the inverted word
  assign cnt_src = op_i[0] ? r0_i : ~r0_i;

  wired_lzc #(
    .WIDTH (32),
    .MODE  (1)
  ) u_lead_cnt (
    .in_i    (cnt_src),
    .cnt_o   (lead_cnt),
    .empty_o (lead_empty)
  );

  wired_lzc #(
    .WIDTH (32),
    .MODE  (0)
  ) u_trail_cnt (
    .in_i    (cnt_src),
    .cnt_o   (trail_cnt),
    .empty_o (trail_empty)
  );

  assign sel_cnt   = op_i[1] ? trail_cnt : lead_cnt;
  assign sel_empty = op_i[1] ? trail_empty : lead_empty;
  // empty word gives 32
  assign cnt_res   = {26'd0, sel_empty, sel_cnt};

  // ====================
  // misc
  // ====================
  always_comb
  begin
    case (op_i)
      ALU_STYPE_EXTB:    misc_res = {{24{r0_i[7]}}, r0_i[7:0]};
      ALU_STYPE_EXTH:    misc_res = {{16{r0_i[15]}}, r0_i[15:0]};
      ALU_STYPE_MASKNEZ: misc_res = (r0_i != '0) ? '0 : r1_i;
      ALU_STYPE_MASKEQZ: misc_res = (r0_i == '0) ? '0 : r1_i;
      default:           misc_res = '0;
    endcase
  end

endmodule

//--- verilog/wired_regfile.sv
module wired_regfile #(
  parameter int NUM_LANES = 2
) (
  input  logic                                  clk,
  input  logic                                  reset_i,
  input  wired_pkg::reg_idx_t [2*NUM_LANES-1:0] rd_idx_i,
  output logic [2*NUM_LANES-1:0][31:0]          rd_data_o,
  input  logic [NUM_LANES-1:0]                  we_i,
  input  wired_pkg::reg_idx_t [NUM_LANES-1:0]   wa_i,
  input  logic [NUM_LANES-1:0][31:0]            wd_i
);

  // r0 has no storage
  logic [31:0] regs [1:31];

  // later lanes overwrite earlier ones
  always_ff @(posedge clk)
  begin
    if (reset_i)
    begin
      for (int i = 1; i < 32; i++)
        regs[i] <= '0;
    end
    else
    begin
      for (int l = 0; l < NUM_LANES; l++)
      begin
        if (we_i[l] && (wa_i[l] != '0))
          regs[wa_i[l]] <= wd_i[l];
      end
    end
  end

  // read with bypass of this cycle's writes
  always_comb
  begin
    for (int p = 0; p < 2 * NUM_LANES; p++)
    begin
      rd_data_o[p] = '0;
      if (rd_idx_i[p] != '0)
      begin
        rd_data_o[p] = regs[rd_idx_i[p]];
        for (int l = 0; l < NUM_LANES; l++)
        begin
          if (we_i[l] && (wa_i[l] == rd_idx_i[p]))
            rd_data_o[p] = wd_i[l];
        end
      end
    end
  end

endmodule

//--- verilog/wired_issue.sv
module wired_issue #(
  parameter int NUM_LANES = 2
) (
  input  logic                                  clk,
  input  logic                                  reset_i,
  input  wired_pkg::uop_t [NUM_LANES-1:0]       issue_i,
  output wired_pkg::reg_idx_t [2*NUM_LANES-1:0] rs_idx_o,
  input  logic [2*NUM_LANES-1:0][31:0]          rs_data_i,
  output wired_pkg::exec_t [NUM_LANES-1:0]      exec_o
);

  import wired_pkg::*;

  exec_t [NUM_LANES-1:0] exec_d;

  // two read ports per lane, rs0 on the even one
  always_comb
  begin
    for (int k = 0; k < NUM_LANES; k++)
    begin
      rs_idx_o[2*k]   = issue_i[k].rs0;
      rs_idx_o[2*k+1] = issue_i[k].rs1;
    end
  end

  // operand select
  always_comb
  begin
    for (int k = 0; k < NUM_LANES; k++)
    begin
      exec_d[k].valid = issue_i[k].valid;
      exec_d[k].gtype = issue_i[k].gtype;
      exec_d[k].op    = issue_i[k].op;
      if (issue_i[k].use_imm)
        exec_d[k].r0 = {12'd0, issue_i[k].imm};
      else
        exec_d[k].r0 = rs_data_i[2*k];
      exec_d[k].r1    = rs_data_i[2*k+1];
      exec_d[k].pc    = issue_i[k].pc;
      exec_d[k].rd    = issue_i[k].rd;
    end
  end

  // ====================
  // issue register
  // ====================
  always_ff @(posedge clk)
  begin
    for (int k = 0; k < NUM_LANES; k++)
    begin
      exec_o[k].gtype <= exec_d[k].gtype;
      exec_o[k].op    <= exec_d[k].op;
      exec_o[k].r0    <= exec_d[k].r0;
      exec_o[k].r1    <= exec_d[k].r1;
      exec_o[k].pc    <= exec_d[k].pc;
      exec_o[k].rd    <= exec_d[k].rd;
      if (reset_i)
        exec_o[k].valid <= 1'b0;
      else
        exec_o[k].valid <= exec_d[k].valid;
    end
  end

endmodule

//--- verilog/wired_commit.sv
module wired_commit #(
  parameter int NUM_LANES = 2
) (
  input  logic                                clk,
  input  logic                                reset_i,
  input  wired_pkg::exec_t [NUM_LANES-1:0]    exec_i,
  input  logic [NUM_LANES-1:0][31:0]          res_i,
  output logic [NUM_LANES-1:0]                we_o,
  output wired_pkg::reg_idx_t [NUM_LANES-1:0] wa_o,
  output logic [NUM_LANES-1:0][31:0]          wd_o,
  output wired_pkg::retire_t [NUM_LANES-1:0]  retire_o
);

  // write-back lands on the same edge as the retire record
  always_comb
  begin
    for (int k = 0; k < NUM_LANES; k++)
    begin
      // r0 writes dropped here
      we_o[k] = exec_i[k].valid && (exec_i[k].rd != '0);
      wa_o[k] = exec_i[k].rd;
      wd_o[k] = res_i[k];
    end
  end

  // ====================
  // retire register
  // ====================
  always_ff @(posedge clk)
  begin
    for (int k = 0; k < NUM_LANES; k++)
    begin
      retire_o[k].rd   <= exec_i[k].rd;
      retire_o[k].data <= res_i[k];
      if (reset_i)
        retire_o[k].valid <= 1'b0;
      else
        retire_o[k].valid <= exec_i[k].valid;
    end
  end

endmodule

//--- verilog/wired_alu_top.sv
module wired_alu_top #(
  parameter int NUM_LANES = 2
) (
  input  logic                               clk,
  input  logic                               reset_i,
  input  wired_pkg::uop_t [NUM_LANES-1:0]    issue_i,
  output wired_pkg::retire_t [NUM_LANES-1:0] retire_o
);

  import wired_pkg::*;

  reg_idx_t [2*NUM_LANES-1:0]    rs_idx;
  logic [2*NUM_LANES-1:0][31:0]  rs_data;
  exec_t [NUM_LANES-1:0]         exec;
  logic [NUM_LANES-1:0][31:0]    res;
  logic [NUM_LANES-1:0]          we;
  reg_idx_t [NUM_LANES-1:0]      wa;
  logic [NUM_LANES-1:0][31:0]    wd;

  wired_issue #(.NUM_LANES(NUM_LANES)) u_issue (
    .clk       (clk),
    .reset_i   (reset_i),
    .issue_i   (issue_i),
    .rs_idx_o  (rs_idx),
    .rs_data_i (rs_data),
    .exec_o    (exec)
  );

  wired_regfile #(.NUM_LANES(NUM_LANES)) u_regfile (
    .clk       (clk),
    .reset_i   (reset_i),
    .rd_idx_i  (rs_idx),
    .rd_data_o (rs_data),
    .we_i      (we),
    .wa_i      (wa),
    .wd_i      (wd)
  );

  // one alu per lane
  for (genvar k = 0; k < NUM_LANES; k++)
  begin : g_lane
    wired_alu u_alu (
      .r0_i       (exec[k].r0),
      .r1_i       (exec[k].r1),
      .pc_i       (exec[k].pc),
      .grand_op_i (exec[k].gtype),
      .op_i       (exec[k].op),
      .res_o      (res[k])
    );
  end

  wired_commit #(.NUM_LANES(NUM_LANES)) u_commit (
    .clk      (clk),
    .reset_i  (reset_i),
    .exec_i   (exec),
    .res_i    (res),
    .we_o     (we),
    .wa_o     (wa),
    .wd_o     (wd),
    .retire_o (retire_o)
  );

endmodule

//--- sim/wired_alu_props.sv
module wired_alu_props #(
  parameter int NUM_LANES = 2
) (
  input logic                               clk,
  input logic                               reset_i,
  input wired_pkg::uop_t [NUM_LANES-1:0]    issue_i,
  input wired_pkg::retire_t [NUM_LANES-1:0] retire_o
);

  import wired_pkg::*;

  logic                       fail_flag = 1'b0;
  logic [31:0]                shadow [0:31];
  logic [NUM_LANES-1:0][31:0] ref_res;
  // expected retire records, one stage per cycle of latency
  retire_t [NUM_LANES-1:0]    exp_a;
  retire_t [NUM_LANES-1:0]    exp_b;

  // length of the run of bit_val starting at one end
  function automatic logic [31:0] run_len(input logic [31:0] v, input logic bit_val,
                                          input logic from_top);
    logic [31:0] n;
    logic        stop;
    int          idx;
    n    = '0;
    stop = 1'b0;
    for (int i = 0; i < 32; i++)
    begin
      idx = from_top ? 31 - i : i;
      if (!stop && (v[idx] == bit_val))
        n++;
      else
        stop = 1'b1;
    end
    return n;
  endfunction

  function automatic logic [31:0] ref_alu(input logic [2:0] g, input logic [2:0] op,
                                          input logic [31:0] r0, input logic [31:0] r1,
                                          input logic [31:0] pc);
    logic [31:0] res;
    logic [31:0] up;
    logic [31:0] sum;
    logic [63:0] dbl;
    res = '0;
    up  = {r0[19:0], 12'h000};
    sum = pc + up;
    dbl = {r1, r1} >> r0[4:0];
    case (g)
      ALU_GTYPE_BW:
        case (op)
          ALU_STYPE_NOR:  res = ~(r0 | r1);
          ALU_STYPE_AND:  res = r0 & r1;
          ALU_STYPE_OR:   res = r0 | r1;
          ALU_STYPE_XOR:  res = r0 ^ r1;
          ALU_STYPE_ANDN: res = r1 & ~r0;
          ALU_STYPE_ORN:  res = r1 | ~r0;
          default:        res = '0;
        endcase
      ALU_GTYPE_LI:
        case (op)
          ALU_STYPE_LUI:       res = up;
          ALU_STYPE_PCPLUS4:   res = pc + 32'd4;
          ALU_STYPE_PCADDU12I: res = sum;
          ALU_STYPE_PCADDI:    res = pc + {{10{r0[19]}}, r0[19:0], 2'b00};
          ALU_STYPE_PCALAU12I: res = {sum[31:12], 12'h000};
          default:             res = '0;
        endcase
      ALU_GTYPE_INT:
        case (op)
          ALU_STYPE_ADD:  res = r1 + r0;
          ALU_STYPE_SUB:  res = r1 - r0;
          ALU_STYPE_SLT:  res = {31'd0, $signed(r1) < $signed(r0)};
          ALU_STYPE_SLTU: res = {31'd0, r1 < r0};
          default:        res = '0;
        endcase
      ALU_GTYPE_SFT:
        case (op)
          ALU_STYPE_SRA:  res = $signed(r1) >>> r0[4:0];
          ALU_STYPE_SRL:  res = r1 >> r0[4:0];
          ALU_STYPE_SLL:  res = r1 << r0[4:0];
          ALU_STYPE_ROTR: res = dbl[31:0];
          default:        res = '0;
        endcase
      // op bit 0 picks zeros, op bit 1 picks the low end
      ALU_GTYPE_COUNT: res = run_len(r0, ~op[0], ~op[1]);
      ALU_GTYPE_MISC:
        case (op)
          ALU_STYPE_EXTB:    res = {{24{r0[7]}}, r0[7:0]};
          ALU_STYPE_EXTH:    res = {{16{r0[15]}}, r0[15:0]};
          ALU_STYPE_MASKNEZ: res = (r0 != '0) ? '0 : r1;
          ALU_STYPE_MASKEQZ: res = (r0 == '0) ? '0 : r1;
          default:           res = '0;
        endcase
      default: res = '0;
    endcase
    return res;
  endfunction

  always_comb
  begin
    for (int k = 0; k < NUM_LANES; k++)
      ref_res[k] = ref_alu(issue_i[k].gtype, issue_i[k].op,
                           issue_i[k].use_imm ? {12'd0, issue_i[k].imm} : shadow[issue_i[k].rs0],
                           shadow[issue_i[k].rs1], issue_i[k].pc);
  end

  // ====================
  // shadow state
  // ====================
  // lanes read state from before the bundle, higher lane wins on rd
  always_ff @(posedge clk)
  begin
    if (reset_i)
    begin
      for (int i = 0; i < 32; i++)
        shadow[i] <= '0;
      exp_a <= '0;
      exp_b <= '0;
    end
    else
    begin
      exp_b <= exp_a;
      for (int k = 0; k < NUM_LANES; k++)
      begin
        exp_a[k].valid <= issue_i[k].valid;
        exp_a[k].rd    <= issue_i[k].rd;
        exp_a[k].data  <= ref_res[k];
        if (issue_i[k].valid && (issue_i[k].rd != '0))
          shadow[issue_i[k].rd] <= ref_res[k];
      end
    end
  end

  // ====================
  // checks
  // ====================
  for (genvar k = 0; k < NUM_LANES; k++)
  begin : g_lane_chk
    a_reset_quiet: assert property (@(posedge clk) reset_i |=> !retire_o[k].valid)
      else
      begin
        $error("MISMATCH %0t retire_o[%0d].valid expected 0 actual %b",
               $time, k, $sampled(retire_o[k].valid));
        fail_flag = 1'b1;
      end

    a_release_quiet: assert property (@(posedge clk)
        $fell(reset_i) |-> !retire_o[k].valid ##1 !retire_o[k].valid)
      else
      begin
        $error("MISMATCH %0t retire_o[%0d].valid expected 0 actual %b",
               $time, k, $sampled(retire_o[k].valid));
        fail_flag = 1'b1;
      end

    a_valid: assert property (@(posedge clk) disable iff (reset_i)
        retire_o[k].valid == exp_b[k].valid)
      else
      begin
        $error("MISMATCH %0t retire_o[%0d].valid expected %b actual %b",
               $time, k, $sampled(exp_b[k].valid), $sampled(retire_o[k].valid));
        fail_flag = 1'b1;
      end

    a_rd: assert property (@(posedge clk) disable iff (reset_i)
        exp_b[k].valid |-> retire_o[k].rd == exp_b[k].rd)
      else
      begin
        $error("MISMATCH %0t retire_o[%0d].rd expected %0d actual %0d",
               $time, k, $sampled(exp_b[k].rd), $sampled(retire_o[k].rd));
        fail_flag = 1'b1;
      end

    a_data: assert property (@(posedge clk) disable iff (reset_i)
        exp_b[k].valid |-> retire_o[k].data == exp_b[k].data)
      else
      begin
        $error("MISMATCH %0t retire_o[%0d].data expected %h actual %h",
               $time, k, $sampled(exp_b[k].data), $sampled(retire_o[k].data));
        fail_flag = 1'b1;
      end
  end

endmodule

bind wired_alu_top wired_alu_props #(.NUM_LANES(NUM_LANES)) u_props (
  .clk      (clk),
  .reset_i  (reset_i),
  .issue_i  (issue_i),
  .retire_o (retire_o)
);

//--- sim/tb_wired_alu_top.sv
module tb_wired_alu_top;

  import wired_pkg::*;

  localparam int NUM_LANES        = 2;
  localparam int RESET_CYCLES     = 3;
  localparam int DIRECTED_BUNDLES = 72;
  localparam int RANDOM_BUNDLES   = 300;
  // margin covers the idle cycles around each phase and the drain
  localparam int MAX_CYCLES = RESET_CYCLES + DIRECTED_BUNDLES + RANDOM_BUNDLES + 25;

  logic                    clk;
  logic                    reset_i;
  uop_t [NUM_LANES-1:0]    issue;
  retire_t [NUM_LANES-1:0] retire;
  integer                  seed;
  int                      cycle_count = 0;

  logic [31:0] pc_tab [4] = '{32'h0000_0ffc, 32'hffff_fffc, 32'h8000_0000, 32'h0000_1000};
  logic [19:0] imm_tab [4] = '{20'h00000, 20'hfffff, 20'h80000, 20'h0001f};

  wired_alu_top #(.NUM_LANES(NUM_LANES)) u_wired_alu_top (
    .clk      (clk),
    .reset_i  (reset_i),
    .issue_i  (issue),
    .retire_o (retire)
  );

  always #20 clk = ~clk;

  function automatic uop_t make_uop(input alu_gtype_e gtype, input logic [2:0] op,
                                    input reg_idx_t rs0, input reg_idx_t rs1,
                                    input logic use_imm, input logic [19:0] imm,
                                    input reg_idx_t rd, input logic [31:0] pc);
    uop_t u;
    u.valid   = 1'b1;
    u.gtype   = gtype;
    u.op      = op;
    u.rs0     = rs0;
    u.rs1     = rs1;
    u.use_imm = use_imm;
    u.imm     = imm;
    u.rd      = rd;
    u.pc      = pc;
    return u;
  endfunction

  // register pool of six keeps dependencies frequent
  function automatic uop_t random_uop();
    uop_t        u;
    logic [31:0] r;
    r         = $random(seed);
    u.valid   = (r[2:0] != 3'd0);
    u.gtype   = alu_gtype_e'(r[5:3]);
    u.op      = r[8:6];
    u.use_imm = r[9];
    u.rs0     = reg_idx_t'({$random(seed)} % 6);
    u.rs1     = reg_idx_t'({$random(seed)} % 6);
    u.rd      = reg_idx_t'({$random(seed)} % 6);
    r         = $random(seed);
    u.imm     = r[19:0];
    u.pc      = $random(seed);
    return u;
  endfunction

  task automatic send(input uop_t lane0, input uop_t lane1);
    @(posedge clk);
    #2;
    issue[0] = lane0;
    issue[1] = lane1;
  endtask

  // upper bits by LUI, low bits by OR with the immediate
  task automatic load_pair(input reg_idx_t ra, input logic [31:0] va,
                           input reg_idx_t rb, input logic [31:0] vb);
    send(make_uop(ALU_GTYPE_LI, ALU_STYPE_LUI, 5'd0, 5'd0, 1'b1, va[31:12], ra, '0),
         make_uop(ALU_GTYPE_LI, ALU_STYPE_LUI, 5'd0, 5'd0, 1'b1, vb[31:12], rb, '0));
    send(make_uop(ALU_GTYPE_BW, ALU_STYPE_OR, 5'd0, ra, 1'b1, {8'd0, va[11:0]}, ra, '0),
         make_uop(ALU_GTYPE_BW, ALU_STYPE_OR, 5'd0, rb, 1'b1, {8'd0, vb[11:0]}, rb, '0));
  endtask

  // every group and subtype, unused codes included
  task automatic directed_sweep();
    for (int g = 0; g < 6; g++)
      for (int op = 0; op < 8; op++)
        send(make_uop(alu_gtype_e'(g), 3'(op), reg_idx_t'(1 + op % 6),
                      reg_idx_t'(1 + (op + g + 1) % 6), 1'b0, '0, 5'd8, pc_tab[op % 4]),
             make_uop(alu_gtype_e'(g), 3'(op), 5'd0, reg_idx_t'(1 + (g + op) % 6), 1'b1,
                      imm_tab[(g + op) % 4], 5'd9, pc_tab[(op + 1) % 4]));
  endtask

  task automatic edge_cases();
    // compares across the sign bit
    send(make_uop(ALU_GTYPE_INT, ALU_STYPE_SLT, 5'd6, 5'd3, 1'b0, '0, 5'd8, '0),
         make_uop(ALU_GTYPE_INT, ALU_STYPE_SLTU, 5'd6, 5'd3, 1'b0, '0, 5'd9, '0));
    send(make_uop(ALU_GTYPE_INT, ALU_STYPE_SLT, 5'd1, 5'd2, 1'b0, '0, 5'd8, '0),
         make_uop(ALU_GTYPE_INT, ALU_STYPE_SLTU, 5'd1, 5'd2, 1'b0, '0, 5'd9, '0));
    // rotate by 0 and by 31
    send(make_uop(ALU_GTYPE_SFT, ALU_STYPE_ROTR, 5'd1, 5'd5, 1'b0, '0, 5'd8, '0),
         make_uop(ALU_GTYPE_SFT, ALU_STYPE_ROTR, 5'd4, 5'd5, 1'b0, '0, 5'd9, '0));
    send(make_uop(ALU_GTYPE_SFT, ALU_STYPE_SRA, 5'd4, 5'd3, 1'b0, '0, 5'd8, '0),
         make_uop(ALU_GTYPE_SFT, ALU_STYPE_SLL, 5'd0, 5'd2, 1'b1, 20'h0, 5'd9, '0));
    // counts of 32
    send(make_uop(ALU_GTYPE_COUNT, ALU_STYPE_CLZ, 5'd1, 5'd0, 1'b0, '0, 5'd8, '0),
         make_uop(ALU_GTYPE_COUNT, ALU_STYPE_CLO, 5'd2, 5'd0, 1'b0, '0, 5'd9, '0));
    send(make_uop(ALU_GTYPE_COUNT, ALU_STYPE_CTZ, 5'd1, 5'd0, 1'b0, '0, 5'd8, '0),
         make_uop(ALU_GTYPE_COUNT, ALU_STYPE_CTO, 5'd2, 5'd0, 1'b0, '0, 5'd9, '0));
    // page crossing pc
    send(make_uop(ALU_GTYPE_LI, ALU_STYPE_PCALAU12I, 5'd0, 5'd0, 1'b1, 20'h1, 5'd8,
                  32'h0000_0ffc),
         make_uop(ALU_GTYPE_LI, ALU_STYPE_PCADDI, 5'd0, 5'd0, 1'b1, 20'hfffff, 5'd9,
                  32'hffff_fffc));
    // x0 stays zero after a write
    send(make_uop(ALU_GTYPE_INT, ALU_STYPE_ADD, 5'd2, 5'd5, 1'b0, '0, 5'd0, '0), '0);
    send(make_uop(ALU_GTYPE_BW, ALU_STYPE_OR, 5'd0, 5'd0, 1'b0, '0, 5'd10, '0), '0);
    // same rd in both lanes, then read back
    send(make_uop(ALU_GTYPE_BW, ALU_STYPE_XOR, 5'd5, 5'd2, 1'b0, '0, 5'd12, '0),
         make_uop(ALU_GTYPE_INT, ALU_STYPE_ADD, 5'd5, 5'd6, 1'b0, '0, 5'd12, '0));
    send(make_uop(ALU_GTYPE_BW, ALU_STYPE_OR, 5'd1, 5'd12, 1'b0, '0, 5'd13, '0), '0);
  endtask

  always @(negedge clk)
  begin
    if (u_wired_alu_top.u_props.fail_flag)
    begin
      $display("TEST FAIL");
      $fatal(1, "a bound assertion failed, run stopped");
    end
  end

  always @(posedge clk)
  begin
    cycle_count = cycle_count + 1;
    if (cycle_count >= MAX_CYCLES)
    begin
      $display("TEST FAIL");
      $fatal(1, "timeout: run did not finish within %0d cycles", MAX_CYCLES);
    end
  end

  initial
  begin
    seed    = 70068;
    clk     = 1'b0;
    reset_i = 1'b1;
    issue   = '0;
    repeat (RESET_CYCLES) @(posedge clk);
    #2;
    reset_i = 1'b0;
    // x1..x6 hold the edge operands
    load_pair(5'd1, 32'h0000_0000, 5'd2, 32'hffff_ffff);
    load_pair(5'd3, 32'h8000_0000, 5'd4, 32'h0000_001f);
    load_pair(5'd5, 32'h1234_5678, 5'd6, 32'h7fff_ffff);
    directed_sweep();
    edge_cases();
    for (int n = 0; n < RANDOM_BUNDLES; n++)
      send(random_uop(), random_uop());
    send('0, '0);
    // last bundle retires two edges on and is checked at the third
    repeat (3) @(posedge clk);
    @(negedge clk);
    if (u_wired_alu_top.u_props.fail_flag)
    begin
      $display("TEST FAIL");
      $fatal(1, "bound checker flagged an error");
    end
    else
    begin
      $display("TEST PASS");
      $finish;
    end
  end

endmodule

//--- wired_alu_top.f
verilog/wired_pkg.sv
verilog/wired_lzc.sv
verilog/wired_alu.sv
verilog/wired_regfile.sv
verilog/wired_issue.sv
verilog/wired_commit.sv
verilog/wired_alu_top.sv
sim/wired_alu_props.sv
sim/tb_wired_alu_top.sv
